//--- src/ahb_arb_pkg.sv
// AHB slave arbiter
// Shared types and constants

package ahb_arb_pkg;

  // ====================
  // Sizing
  // ====================

  // Masters competing for the slave
  localparam int MASTER_NUM = 4;

  // Width of one rank entry
  localparam int PRIOR_BIT = $clog2(MASTER_NUM);

  // One bit per master, used for requests, grants and last-beat pulses
  typedef logic [MASTER_NUM-1:0] master_vec_t;

  // Rank of one master; larger means it has waited longer
  typedef logic [PRIOR_BIT-1:0] prior_t;

  // One rank per master
  typedef prior_t [MASTER_NUM-1:0] prior_tab_t;

  // ====================
  // Burst encoding
  // ====================

  typedef logic [2:0] hburst_t;

  localparam hburst_t SINGLE = 3'd0;
  localparam hburst_t INCR   = 3'd1;
  localparam hburst_t WRAP4  = 3'd2;
  localparam hburst_t INCR4  = 3'd3;
  localparam hburst_t WRAP8  = 3'd4;
  localparam hburst_t INCR8  = 3'd5;
  localparam hburst_t WRAP16 = 3'd6;
  localparam hburst_t INCR16 = 3'd7;

  // Beat counter, long enough for a 16-beat burst
  typedef logic [3:0] beat_cnt_t;

  // ====================
  // Stage interfaces
  // ====================

  // Registered grant and bus-owned flag
  typedef struct packed {
    master_vec_t owner;
    logic        active;
  } grant_s;

  // Last unstalled beat of the owner's burst
  typedef struct packed {
    master_vec_t last;
    logic        done;
  } burst_end_s;

  // Burst monitor FSM
  typedef enum logic {
    MON_IDLE,
    MON_COUNT
  } mon_state_e;

endpackage

//--- src/prior_table.sv
// Round-robin rank table

`timescale 1ns/100ps

module prior_table
  import ahb_arb_pkg::*;
(
  input  logic       hclk,
  input  logic       hreset_n,
  input  grant_s     grant,
  input  burst_end_s burst_end,
  output prior_tab_t ranks
);

  // ====================
  // Internal signals
  // ====================

  prior_tab_t rank_q;
  prior_tab_t rank_next;
  prior_t     owner_rank;

  // ====================
  // Owner rank lookup
  // ====================

  // One-hot mux on the owner vector
  always_comb
  begin
    owner_rank = '0;
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      owner_rank = owner_rank | (rank_q[i] & {PRIOR_BIT{grant.owner[i]}});
    end
  end

  // ====================
  // Next rank values
  // ====================

  // Served master drops to the bottom and those below its old rank move up
  always_comb
  begin
    rank_next = rank_q;
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      if (grant.owner[i])
      begin
        rank_next[i] = '0;
      end
      else if (rank_q[i] < owner_rank)
      begin
        rank_next[i] = prior_t'(rank_q[i] + 1'b1);
      end
    end
  end

  // ====================
  // Rank registers
  // ====================

  // Master i starts at rank i, so master 3 wins the first contention
  always_ff @(posedge hclk, negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      for (int i = 0; i < MASTER_NUM; i++)
      begin
        rank_q[i] <= prior_t'(i);
      end
    end
    else if (burst_end.done)
    begin
      rank_q <= rank_next;
    end
  end

  assign ranks = rank_q;

endmodule

//--- src/grant_select.sv
// Grant selection and grant register

`timescale 1ns/100ps

module grant_select
  import ahb_arb_pkg::*;
(
  input  logic        hclk,
  input  logic        hreset_n,
  input  master_vec_t hreq,
  input  prior_tab_t  ranks,
  input  burst_end_s  burst_end,
  output grant_s      grant
);

  // ====================
  // Internal signals
  // ====================

  master_vec_t winner;
  master_vec_t owner_q;
  master_vec_t owner_next;
  prior_t      win_rank;
  logic        win_found;
  logic        bus_active;
  logic        load;

  // ====================
  // Winner search
  // ====================

  // Highest rank among requesters; ranks are a permutation so no ties
  always_comb
  begin
    winner    = '0;
    win_rank  = '0;
    win_found = 1'b0;
    for (int i = 0; i < MASTER_NUM; i++)
    begin
      if (hreq[i] && (!win_found || (ranks[i] > win_rank)))
      begin
        winner    = master_vec_t'(1) << i;
        win_rank  = ranks[i];
        win_found = 1'b1;
      end
    end
  end

  // ====================
  // Hold or reload
  // ====================

  assign bus_active = |owner_q;

  // Idle bus or last beat of the current burst opens a new arbitration
  assign load = ~bus_active | burst_end.done;

  always_comb
  begin
    if (load)
    begin
      owner_next = winner;
    end
    else
    begin
      // Owner keeps the slave for the whole burst
      owner_next = owner_q;
    end
  end

  // ====================
  // Grant register
  // ====================

  always_ff @(posedge hclk, negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      owner_q <= '0;
    end
    else
    begin
      owner_q <= owner_next;
    end
  end

  // Registered grant out to the other stages
  always_comb
  begin
    grant.owner  = owner_q;
    grant.active = bus_active;
  end

endmodule

//--- src/burst_monitor.sv
// Burst monitor
// Beat counting and last-beat detection

`timescale 1ns/100ps

module burst_monitor
  import ahb_arb_pkg::*;
(
  input  logic       hclk,
  input  logic       hreset_n,
  input  grant_s     grant,
  input  hburst_t    hburst,
  input  logic       hwait,
  output burst_end_s burst_end
);

  // ====================
  // Internal signals
  // ====================

  mon_state_e state_q;
  mon_state_e state_next;
  hburst_t    burst_q;
  beat_cnt_t  cnt_q;
  beat_cnt_t  cnt_next;
  beat_cnt_t  cnt_limit;
  logic       at_limit;
  logic       last_beat;
  logic       latch_burst;

  // ====================
  // Beat limit decode
  // ====================

  // Limit is beats minus one
  always_comb
  begin
    unique case (burst_q)
      SINGLE, INCR:   cnt_limit = beat_cnt_t'(0);
      WRAP4, INCR4:   cnt_limit = beat_cnt_t'(3);
      WRAP8, INCR8:   cnt_limit = beat_cnt_t'(7);
      WRAP16, INCR16: cnt_limit = beat_cnt_t'(15);
      default:        cnt_limit = beat_cnt_t'(0);
    endcase
  end

  assign at_limit  = (cnt_q == cnt_limit);

  // Final beat only counts when the slave is not stalling
  assign last_beat = (state_q == MON_COUNT) & at_limit & ~hwait;

  // ====================
  // FSM and counter
  // ====================

  always_comb
  begin
    state_next  = state_q;
    cnt_next    = cnt_q;
    latch_burst = 1'b0;
    unique case (state_q)
      MON_IDLE:
      begin
        cnt_next = '0;
        if (grant.active)
        begin
          latch_burst = 1'b1;
          state_next  = MON_COUNT;
        end
      end
      MON_COUNT:
      begin
        if (last_beat)
        begin
          cnt_next   = '0;
          state_next = MON_IDLE;
        end
        else if (!hwait)
        begin
          cnt_next = cnt_q + 1'b1;
        end
      end
      default:
      begin
        cnt_next   = '0;
        state_next = MON_IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk, negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      state_q <= MON_IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_next;
      cnt_q   <= cnt_next;
    end
  end

  // Burst type of the new owner, held for the rest of the burst
  always_ff @(posedge hclk)
  begin
    if (latch_burst)
    begin
      burst_q <= hburst;
    end
  end

  // ====================
  // Burst end outputs
  // ====================

  always_comb
  begin
    burst_end.last = grant.owner & {MASTER_NUM{last_beat}};
    burst_end.done = |burst_end.last;
  end

endmodule

//--- src/ahb_slave_arbiter.sv
// AHB slave arbiter top

`timescale 1ns/100ps

module ahb_slave_arbiter
  import ahb_arb_pkg::*;
(
  input  logic        hclk,
  input  logic        hreset_n,
  input  master_vec_t hreq,
  input  hburst_t     hburst,
  input  logic        hwait,
  output master_vec_t hgrant,
  output logic        hsel
);

  // ====================
  // Stage links
  // ====================

  prior_tab_t ranks;
  grant_s     grant;
  burst_end_s burst_end;

  // Rank table, rotated at each burst end
  prior_table u_prior_table (
    .hclk      (hclk),
    .hreset_n  (hreset_n),
    .grant     (grant),
    .burst_end (burst_end),
    .ranks     (ranks)
  );

  // Winner pick and grant register
  grant_select u_grant_select (
    .hclk      (hclk),
    .hreset_n  (hreset_n),
    .hreq      (hreq),
    .ranks     (ranks),
    .burst_end (burst_end),
    .grant     (grant)
  );

  // Beat counting for the owner's burst
  burst_monitor u_burst_monitor (
    .hclk      (hclk),
    .hreset_n  (hreset_n),
    .grant     (grant),
    .hburst    (hburst),
    .hwait     (hwait),
    .burst_end (burst_end)
  );

  // ====================
  // Bus pins
  // ====================

  // Grant blanked during slave wait, select stays up
  assign hgrant = grant.owner & ~{MASTER_NUM{hwait}};
  assign hsel   = grant.active;

endmodule

//--- test/tb_ahb_slave_arbiter.sv
// AHB slave arbiter testbench

`timescale 1ns/100ps

module tb_ahb_slave_arbiter
  import ahb_arb_pkg::*;
();

  localparam int    CLK_PERIOD    = 100;
  localparam int    RESET_CYCLES  = 8;
  localparam int    MARGIN_CYCLES = 20;
  localparam string VECTOR_FILE   = "test/arb_input.txt";

  // One line of the vector file
  typedef struct packed {
    master_vec_t hreq;
    hburst_t     hburst;
    logic        hwait;
    master_vec_t exp_grant;
    logic        exp_sel;
  } vector_s;

  logic        hclk = 1'b0;
  logic        hreset_n;
  master_vec_t hreq;
  hburst_t     hburst;
  logic        hwait;
  master_vec_t hgrant;
  logic        hsel;

  vector_s     vec_q[$];
  string       name_q[$];
  vector_s     idle_vec;
  logic        loaded = 1'b0;

  ahb_slave_arbiter u_dut (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hreq     (hreq),
    .hburst   (hburst),
    .hwait    (hwait),
    .hgrant   (hgrant),
    .hsel     (hsel)
  );

  always #(CLK_PERIOD / 2) hclk = ~hclk;

  // ====================
  // Helpers
  // ====================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  function automatic string strip_line_end(input string s);
    string t;
    t = s;
    while ((t.len() > 0) && ((t.getc(t.len() - 1) == 8'h0a) || (t.getc(t.len() - 1) == 8'h0d)))
    begin
      t = t.substr(0, t.len() - 2);
    end
    return t;
  endfunction

  // Whole file goes into queues before the clocked run starts
  task automatic load_vectors();
    int      fd;
    int      code;
    int      n;
    int      v_req;
    int      v_burst;
    int      v_wait;
    int      v_grant;
    int      v_sel;
    string   line;
    string   name;
    vector_s vec;
    name = "unnamed";
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0)
    begin
      abort_run($sformatf("Cannot open the vector file %s", VECTOR_FILE));
    end
    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      line = strip_line_end(line);
      if ((code == 0) || (line.len() == 0))
      begin
        // Blank line or end of file
      end
      else if ((line.len() > 7) && (line.substr(0, 6) == "# test "))
      begin
        name = line.substr(7, line.len() - 1);
      end
      else if (line.getc(0) != 8'h23)
      begin
        n = $sscanf(line, "%h %h %h %h %h", v_req, v_burst, v_wait, v_grant, v_sel);
        if (n != 5)
        begin
          abort_run($sformatf("The vector file has a malformed line: %s", line));
        end
        vec.hreq      = master_vec_t'(v_req);
        vec.hburst    = hburst_t'(v_burst);
        vec.hwait     = v_wait[0];
        vec.exp_grant = master_vec_t'(v_grant);
        vec.exp_sel   = v_sel[0];
        vec_q.push_back(vec);
        name_q.push_back(name);
      end
    end
    $fclose(fd);
  endtask

  task automatic check_outputs(input vector_s vec, input string name);
    assert (hgrant == vec.exp_grant)
    else
    begin
      abort_run($sformatf("Error in test %s: hgrant expected %h, actual %h",
                          name, vec.exp_grant, hgrant));
    end
    assert (hsel == vec.exp_sel)
    else
    begin
      abort_run($sformatf("Error in test %s: hsel expected %h, actual %h",
                          name, vec.exp_sel, hsel));
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    hreset_n = 1'b0;
    hreq     = '0;
    hburst   = SINGLE;
    hwait    = 1'b0;
    idle_vec = '0;
    load_vectors();
    loaded = 1'b1;
    // Outputs must stay low while reset is held
    repeat (RESET_CYCLES)
    begin
      @(negedge hclk);
      check_outputs(idle_vec, "reset");
    end
    hreset_n = 1'b1;
    // Drive on the falling edge, check at the next one
    for (int i = 0; i < vec_q.size(); i++)
    begin
      hreq   = vec_q[i].hreq;
      hburst = vec_q[i].hburst;
      hwait  = vec_q[i].hwait;
      @(negedge hclk);
      check_outputs(vec_q[i], name_q[i]);
    end
    $display("Test completed successfully");
    $finish;
  end

  // Watchdog sized from the vector count
  initial
  begin
    wait (loaded);
    #((vec_q.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    abort_run("Timeout: the vector run did not finish in time");
  end

endmodule

//--- test/arb_input.txt
# Columns in hex are hreq hburst hwait then expected hgrant and hsel
# A line starting with "# test" names the vectors below it
# test reset_idle
0 0 0 0 0
0 0 0 0 0
# test initial_order
f 0 0 8 1
f 0 0 8 1
7 0 0 4 1
f 0 0 4 1
b 0 0 2 1
f 0 0 2 1
d 0 0 1 1
f 0 0 1 1
e 0 0 8 1
# test burst_length
f 3 0 8 1
f 3 0 8 1
f 3 0 8 1
f 3 0 8 1
7 3 0 4 1
f 4 0 4 1
f 4 0 4 1
f 4 0 4 1
f 4 0 4 1
f 4 0 4 1
f 4 0 4 1
f 4 0 4 1
f 4 0 4 1
b 4 0 2 1
# test wait_handling
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 1 0 1
f 7 1 0 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
f 7 0 2 1
0 7 0 0 0
# test fairness
4 0 0 4 1
4 0 0 4 1
0 0 0 0 0
6 0 0 2 1
6 0 0 2 1
4 0 0 4 1
# test release
0 3 0 4 1
0 3 0 4 1
0 3 0 4 1
0 3 0 4 1
0 3 0 0 0
0 0 0 0 0

//--- flist.f
src/ahb_arb_pkg.sv
src/prior_table.sv
src/grant_select.sv
src/burst_monitor.sv
src/ahb_slave_arbiter.sv
test/tb_ahb_slave_arbiter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB slave arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_ahb_slave_arbiter
build_log=build.log
sim_log=sim.log
pass_msg="Test completed successfully"

rm -rf obj_dir "$build_log" "$sim_log"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module "$top" -f flist.f -o "$top" > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status, see $build_log"
  exit 1
fi

./obj_dir/"$top" > "$sim_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see $sim_log"
  exit 1
fi

if grep -qx "$pass_msg" "$sim_log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see $sim_log"
  exit 1
fi
